// File: bench/decd_checker.sv
module decd_checker (
    input  logic                       cpuclk,
    input  logic                       arst_n,
    input  rv32_isa_pkg::inst_t        inst,
    input  logic                       inst_vld,
    input  logic                       decd_vld,
    input  decd_out_pkg::decd_result_t decd,
    input  int                         phase,
    input  logic                       phase_done,
    output int                         error_count,
    output int                         check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import rv32_isa_pkg::*;
    import decd_out_pkg::*;

    int           phase_errs   = 0;
    int           phase_checks = 0;
    int           total_errs   = 0;
    int           total_checks = 0;
    logic         exp_vld      = 1'b0;
    decd_result_t exp_decd     = '0;   // What the output register should hold now

    assign error_count = total_errs;
    assign check_count = total_checks;

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic func_t alu_func(logic [2:0] f3, logic sub, logic sra);
        case (f3)
            3'd0:    return sub ? FUNC_SUB : FUNC_ADD;
            3'd1:    return FUNC_SLL;
            3'd2:    return FUNC_SLT;
            3'd3:    return FUNC_LTU;
            3'd4:    return FUNC_XOR;
            3'd5:    return sra ? FUNC_SRA : FUNC_SRL;
            3'd6:    return FUNC_OR;
            default: return FUNC_AND;
        endcase
    endfunction

    function automatic decd_ctrl_t model_ctrl(inst_t w);
        decd_ctrl_t c;
        logic [2:0] f3;
        func_t      f3w;
        f3  = w[14:12];
        f3w = {3'b000, f3};
        c   = '{SEL_NONE, FUNC_NONE, 1'b0};
        if (w[1:0] == OPC_LOW_BITS)
        begin
            case (w[6:2])
                OPC_OP:
                begin
                    if (!w[25])
                        c = '{SEL_ALU, alu_func(f3, w[30], w[30]), 1'b1};
                    else if (!w[30])   // M extension, codes run MULT to REMU
                        c = '{f3[2] ? SEL_DIV : SEL_MUL, FUNC_MULT + f3w, 1'b1};
                end
                OPC_OP_IMM: c = '{SEL_ALU, alu_func(f3, 1'b0, w[30]), 1'b1};
                OPC_LUI:    c = '{SEL_ALU, FUNC_ADD, 1'b1};
                OPC_AUIPC:  c = '{SEL_BJU, FUNC_AUIPC, 1'b1};
                OPC_JAL:    c = '{SEL_BJU, FUNC_JAL, 1'b1};
                OPC_JALR:   c = '{SEL_BJU, FUNC_JALR, 1'b1};
                OPC_BRANCH:
                    if (f3[2:1] != 2'b01)   // 010 and 011 are holes
                        c = '{SEL_BJU, FUNC_BEQ + f3w - (f3[2] ? 6'd2 : 6'd0), 1'b0};
                OPC_LOAD:
                    if (f3 != 3'd3 && f3 < 3'd6)
                        c = '{SEL_LSU, FUNC_LB + f3w - (f3[2] ? 6'd1 : 6'd0), 1'b1};
                OPC_STORE:
                    if (f3 < 3'd3)
                        c = '{SEL_LSU, FUNC_SB + f3w, 1'b0};
                default:    c = '{SEL_NONE, FUNC_NONE, 1'b0};
            endcase
        end
        return c;
    endfunction

    function automatic decd_opnd_t model_opnd(inst_t w);
        decd_opnd_t o;
        opcode_t    opc;
        imm_t       i_imm, s_imm, b_imm, u_imm, j_imm;
        opc   = w[6:2];
        i_imm = {{20{w[31]}}, w[31:20]};
        s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'h000};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        o          = '0;
        o.rs1_vld  = (opc != OPC_AUIPC) && (opc != OPC_JAL);
        o.rs1      = (opc == OPC_LUI) ? 5'd0 : w[19:15];
        o.rs2_vld  = (opc == OPC_OP) || (opc == OPC_STORE) || (opc == OPC_BRANCH);
        o.imm1_vld = (opc == OPC_OP_IMM) || (opc == OPC_LUI);
        o.imm1     = (opc == OPC_LUI) ? u_imm : ((opc == OPC_OP_IMM) ? i_imm : '0);
        case (opc)
            OPC_LOAD, OPC_JALR: o.imm2 = i_imm;
            OPC_STORE:          o.imm2 = s_imm;
            OPC_BRANCH:         o.imm2 = b_imm;
            OPC_AUIPC:          o.imm2 = u_imm;
            OPC_JAL:            o.imm2 = j_imm;
            default:            o.imm2 = '0;
        endcase
        o.imm2_vld = (opc == OPC_LOAD) || (opc == OPC_JALR) || (opc == OPC_STORE)
                  || (opc == OPC_BRANCH) || (opc == OPC_AUIPC) || (opc == OPC_JAL);
        return o;
    endfunction

    function automatic string phase_name(int ph);
        case (ph)
            1:       return "reset and timing";
            2:       return "ALU decode";
            3:       return "branch, jump and AUIPC decode";
            4:       return "load and store decode";
            5:       return "MUL and DIV decode";
            6:       return "unsupported encodings";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_field(string name, logic [31:0] exp_val, logic [31:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, exp_val, act_val);
            phase_errs++;
        end
    endtask

    // ======================================================================
    // Compare on the falling edge, away from DUT and stimulus updates
    // ======================================================================
    always @(negedge cpuclk)
    begin
        check_field("decd_vld", exp_vld, decd_vld);
        check_field("sel", exp_decd.ctrl.sel, decd.ctrl.sel);
        check_field("func", exp_decd.ctrl.func, decd.ctrl.func);
        check_field("rd_vld", exp_decd.ctrl.rd_vld, decd.ctrl.rd_vld);
        check_field("rs1_vld", exp_decd.opnd.rs1_vld, decd.opnd.rs1_vld);
        check_field("rs1", exp_decd.opnd.rs1, decd.opnd.rs1);
        check_field("rs2_vld", exp_decd.opnd.rs2_vld, decd.opnd.rs2_vld);
        check_field("imm1_vld", exp_decd.opnd.imm1_vld, decd.opnd.imm1_vld);
        check_field("imm1", exp_decd.opnd.imm1, decd.opnd.imm1);
        check_field("imm2_vld", exp_decd.opnd.imm2_vld, decd.opnd.imm2_vld);
        check_field("imm2", exp_decd.opnd.imm2, decd.opnd.imm2);
        phase_checks++;

        if (phase_done)
        begin
            $display("Phase %0d, %s: %0d checks, %0d errors",
                     phase, phase_name(phase), phase_checks, phase_errs);
            total_errs   += phase_errs;
            total_checks += phase_checks;
            phase_errs   = 0;
            phase_checks = 0;
            if (phase == 6)
                $display("Totals: %0d checks, %0d errors", total_checks, total_errs);
        end

        // Inputs here are what the DUT captures at the next rising edge
        if (!arst_n)
        begin
            exp_vld  = 1'b0;
            exp_decd = '0;
        end
        else
        begin
            exp_vld = inst_vld;
            if (inst_vld)
                exp_decd = '{model_ctrl(inst), model_opnd(inst)};   // Else held
        end
    end

endmodule

// File: bench/tb_decd_stage.sv
module tb_decd_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import rv32_isa_pkg::*;
    import decd_out_pkg::*;

    localparam int N_PER_TEST = 400;
    localparam int N_PHASES   = 6;
    // Reset, stimulus, two extra cycles per phase, then a drain margin
    localparam int TIMEOUT_NS = (10 + N_PHASES * (N_PER_TEST + 2) + 50) * 8;

    logic         cpuclk = 1'b0;
    logic         arst_n;
    inst_t        inst;
    logic         inst_vld;
    logic         decd_vld;
    decd_result_t decd;
    int           phase;
    logic         phase_done;
    int           error_count;
    int           check_count;

    always #4 cpuclk = ~cpuclk;

    decd_stage uut (
        .cpuclk   (cpuclk),
        .arst_n   (arst_n),
        .inst     (inst),
        .inst_vld (inst_vld),
        .decd_vld (decd_vld),
        .decd     (decd)
    );

    decd_checker u_checker (
        .cpuclk      (cpuclk),
        .arst_n      (arst_n),
        .inst        (inst),
        .inst_vld    (inst_vld),
        .decd_vld    (decd_vld),
        .decd        (decd),
        .phase       (phase),
        .phase_done  (phase_done),
        .error_count (error_count),
        .check_count (check_count)
    );

    // ======================================================================
    // Random instruction per phase
    // ======================================================================
    function automatic inst_t make_inst(int ph);
        inst_t   w;
        opcode_t opc;
        int      pick;
        if (ph == 1)
            ph = 2 + $urandom % 4;   // Mix of all supported groups
        w    = $urandom;
        pick = $urandom % 6;
        case (ph)
            2:
            begin
                opc = (pick == 0) ? OPC_LUI : ((pick == 1) ? OPC_OP_IMM : OPC_OP);
                if (pick < 4)
                    w[25] = 1'b0;   // Keep most OP words out of the M extension
            end
            3:       opc = (pick < 3) ? OPC_BRANCH : ((pick == 3) ? OPC_JALR
                           : ((pick == 4) ? OPC_JAL : OPC_AUIPC));
            4:       opc = pick[0] ? OPC_STORE : OPC_LOAD;
            5:
            begin
                opc   = OPC_OP;
                w[25] = 1'b1;
                w[30] = 1'b0;
            end
            default:
            begin
                if (pick == 0)
                    return w;   // Fully random word
                opc = w[31] ? 5'b11100 : 5'b00011;   // SYSTEM or MISC_MEM
                if (pick == 2)
                    opc = OPC_OP;
                if (pick == 3)
                    opc = OPC_BRANCH;
                if (pick == 4)
                    opc = OPC_LOAD;
                if (pick == 5)
                    opc = OPC_STORE;
                w[25]    = 1'b1;
                w[30]    = 1'b1;
                w[14:12] = (pick == 3) ? {1'b0, 1'b1, w[12]} : {w[14] | (pick == 5), 2'b11};
            end
        endcase
        w[6:0] = {opc, OPC_LOW_BITS};
        return w;
    endfunction

    initial
    begin
        void'($urandom(32'hd23f_2264));
        arst_n     = 1'b0;
        inst       = '0;
        inst_vld   = 1'b0;
        phase      = 1;
        phase_done = 1'b0;
        repeat (10) @(posedge cpuclk);
        #1 arst_n = 1'b1;
        for (int p = 1; p <= N_PHASES; p++)
        begin
            phase = p;
            repeat (N_PER_TEST)
            begin
                @(posedge cpuclk);
                #1;
                inst     = make_inst(p);
                inst_vld = ($urandom % 10) < 8;
            end
            // The last result is compared in the drain cycle while phase_done is high
            @(posedge cpuclk);
            #1;
            inst_vld   = 1'b0;
            phase_done = 1'b1;
            @(posedge cpuclk);
            #1;
            phase_done = 1'b0;
        end
        if (check_count == 0)
            $display("Error: no DUT results were compared");
        if (error_count == 0 && check_count > 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: list.f
source/rv32_isa_pkg.sv
source/decd_out_pkg.sv
source/decd_func_decoder.sv
source/decd_operand_gen.sv
source/decd_stage.sv
bench/decd_checker.sv
bench/tb_decd_stage.sv

// File: source/decd_func_decoder.sv
module decd_func_decoder (
    input  rv32_isa_pkg::inst_t      inst,
    output decd_out_pkg::decd_ctrl_t ctrl
);

    import rv32_isa_pkg::*;
    import decd_out_pkg::*;

    func7_t  func7;
    func3_t  func3;
    opcode_t opcode;
    logic    opc_ok;

    assign func7  = inst[31:25];
    assign func3  = inst[14:12];
    assign opcode = inst[6:2];
    assign opc_ok = (inst[1:0] == OPC_LOW_BITS);   // Compressed forms not supported

    // Key layout is {func7, func3, opcode}
    // func7[5] is inst bit 30, func7[0] is inst bit 25
    always_comb
    begin
        ctrl = '{SEL_NONE, FUNC_NONE, 1'b0};
        if (opc_ok)
        begin
            casez ({func7, func3, opcode})
                // ==========================================================
                // ALU, register forms
                // ==========================================================
                {7'b?0????0, 3'b000, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_ADD, 1'b1};
                {7'b?1????0, 3'b000, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_SUB, 1'b1};
                {7'b??????0, 3'b001, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_SLL, 1'b1};
                {7'b??????0, 3'b010, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_SLT, 1'b1};
                {7'b??????0, 3'b011, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_LTU, 1'b1};
                {7'b??????0, 3'b100, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_XOR, 1'b1};
                {7'b?0????0, 3'b101, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_SRL, 1'b1};
                {7'b?1????0, 3'b101, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_SRA, 1'b1};
                {7'b??????0, 3'b110, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_OR, 1'b1};
                {7'b??????0, 3'b111, OPC_OP}:     ctrl = '{SEL_ALU, FUNC_AND, 1'b1};

                // Immediate forms, func7 is immediate data except for shifts
                {7'b???????, 3'b000, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_ADD, 1'b1};
                {7'b???????, 3'b001, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_SLL, 1'b1};
                {7'b???????, 3'b010, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_SLT, 1'b1};
                {7'b???????, 3'b011, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_LTU, 1'b1};
                {7'b???????, 3'b100, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_XOR, 1'b1};
                {7'b?0?????, 3'b101, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_SRL, 1'b1};
                {7'b?1?????, 3'b101, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_SRA, 1'b1};
                {7'b???????, 3'b110, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_OR, 1'b1};
                {7'b???????, 3'b111, OPC_OP_IMM}: ctrl = '{SEL_ALU, FUNC_AND, 1'b1};

                // LUI is an add of the U immediate to zero
                {7'b???????, 3'b???, OPC_LUI}:    ctrl = '{SEL_ALU, FUNC_ADD, 1'b1};

                // ==========================================================
                // BJU
                // ==========================================================
                {7'b???????, 3'b???, OPC_AUIPC}:  ctrl = '{SEL_BJU, FUNC_AUIPC, 1'b1};
                {7'b???????, 3'b???, OPC_JAL}:    ctrl = '{SEL_BJU, FUNC_JAL, 1'b1};
                {7'b???????, 3'b???, OPC_JALR}:   ctrl = '{SEL_BJU, FUNC_JALR, 1'b1};

                // Branches never write rd
                {7'b???????, 3'b000, OPC_BRANCH}: ctrl = '{SEL_BJU, FUNC_BEQ, 1'b0};
                {7'b???????, 3'b001, OPC_BRANCH}: ctrl = '{SEL_BJU, FUNC_BNE, 1'b0};
                {7'b???????, 3'b100, OPC_BRANCH}: ctrl = '{SEL_BJU, FUNC_BLT, 1'b0};
                {7'b???????, 3'b101, OPC_BRANCH}: ctrl = '{SEL_BJU, FUNC_BGE, 1'b0};
                {7'b???????, 3'b110, OPC_BRANCH}: ctrl = '{SEL_BJU, FUNC_BLTU, 1'b0};
                {7'b???????, 3'b111, OPC_BRANCH}: ctrl = '{SEL_BJU, FUNC_BGEU, 1'b0};

                // ==========================================================
                // LSU
                // ==========================================================
                {7'b???????, 3'b000, OPC_LOAD}:   ctrl = '{SEL_LSU, FUNC_LB, 1'b1};
                {7'b???????, 3'b001, OPC_LOAD}:   ctrl = '{SEL_LSU, FUNC_LH, 1'b1};
                {7'b???????, 3'b010, OPC_LOAD}:   ctrl = '{SEL_LSU, FUNC_LW, 1'b1};
                {7'b???????, 3'b100, OPC_LOAD}:   ctrl = '{SEL_LSU, FUNC_LBU, 1'b1};
                {7'b???????, 3'b101, OPC_LOAD}:   ctrl = '{SEL_LSU, FUNC_LHU, 1'b1};

                {7'b???????, 3'b000, OPC_STORE}:  ctrl = '{SEL_LSU, FUNC_SB, 1'b0};
                {7'b???????, 3'b001, OPC_STORE}:  ctrl = '{SEL_LSU, FUNC_SH, 1'b0};
                {7'b???????, 3'b010, OPC_STORE}:  ctrl = '{SEL_LSU, FUNC_SW, 1'b0};

                // ==========================================================
                // MUL and DIV, bit 25 set with bit 30 clear
                // ==========================================================
                {7'b?0????1, 3'b000, OPC_OP}:     ctrl = '{SEL_MUL, FUNC_MULT, 1'b1};
                {7'b?0????1, 3'b001, OPC_OP}:     ctrl = '{SEL_MUL, FUNC_MULH, 1'b1};
                {7'b?0????1, 3'b010, OPC_OP}:     ctrl = '{SEL_MUL, FUNC_MULHSU, 1'b1};
                {7'b?0????1, 3'b011, OPC_OP}:     ctrl = '{SEL_MUL, FUNC_MULHU, 1'b1};

                {7'b?0????1, 3'b100, OPC_OP}:     ctrl = '{SEL_DIV, FUNC_DIVS, 1'b1};
                {7'b?0????1, 3'b101, OPC_OP}:     ctrl = '{SEL_DIV, FUNC_DIVU, 1'b1};
                {7'b?0????1, 3'b110, OPC_OP}:     ctrl = '{SEL_DIV, FUNC_REMS, 1'b1};
                {7'b?0????1, 3'b111, OPC_OP}:     ctrl = '{SEL_DIV, FUNC_REMU, 1'b1};

                // Anything else is left as no unit, no write
                default:                          ctrl = '{SEL_NONE, FUNC_NONE, 1'b0};
            endcase
        end
    end

    // At most one execution unit across the whole table
    a_sel_onehot0: assert final ($isunknown(inst) || $onehot0(ctrl.sel))
        else $error("decd_func_decoder: select 0x%0h is not one-hot", ctrl.sel);

endmodule

// File: source/decd_operand_gen.sv
module decd_operand_gen (
    input  rv32_isa_pkg::inst_t      inst,
    output decd_out_pkg::decd_opnd_t opnd
);

    import rv32_isa_pkg::*;

    opcode_t  opcode;
    reg_idx_t rs1_field;
    logic     rs1_vld;
    reg_idx_t rs1;
    logic     rs2_vld;

    imm_t     itype_imm;
    imm_t     stype_imm;
    imm_t     btype_imm;
    imm_t     utype_imm;
    imm_t     jtype_imm;

    logic     imm1_vld;
    imm_t     imm1;
    logic     imm2_vld;
    imm_t     imm2;

    assign opcode    = inst[6:2];
    assign rs1_field = inst[19:15];

    // ======================================================================
    // Register indices
    // ======================================================================
    assign rs1_vld = (opcode != OPC_AUIPC) && (opcode != OPC_JAL);
    assign rs1     = (opcode == OPC_LUI) ? '0 : rs1_field;   // LUI adds to x0
    assign rs2_vld = (opcode == OPC_OP)
                  || (opcode == OPC_STORE)
                  || (opcode == OPC_BRANCH);

    // ======================================================================
    // Immediate formats
    // ======================================================================
    assign itype_imm = {{21{inst[31]}}, inst[30:20]};
    assign stype_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign btype_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign utype_imm = {inst[31:12], 12'b0};
    assign jtype_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Operand immediate for the ALU
    always_comb
    begin
        imm1_vld = 1'b0;
        imm1     = '0;
        case (opcode)
            OPC_OP_IMM:
            begin
                imm1_vld = 1'b1;
                imm1     = itype_imm;
            end
            OPC_LUI:
            begin
                imm1_vld = 1'b1;
                imm1     = utype_imm;
            end
            default:
            begin
                imm1_vld = 1'b0;
                imm1     = '0;
            end
        endcase
    end

    // Address offset for BJU and LSU
    always_comb
    begin
        imm2_vld = 1'b1;
        case (opcode)
            OPC_LOAD,
            OPC_JALR:   imm2 = itype_imm;
            OPC_STORE:  imm2 = stype_imm;
            OPC_BRANCH: imm2 = btype_imm;
            OPC_AUIPC:  imm2 = utype_imm;
            OPC_JAL:    imm2 = jtype_imm;
            default:
            begin
                imm2_vld = 1'b0;
                imm2     = '0;
            end
        endcase
    end

    assign opnd = '{rs1_vld, rs1, rs2_vld, imm1_vld, imm1, imm2_vld, imm2};

    // ALU and offset immediates come from disjoint opcode sets
    a_imm_excl: assert final (!(opnd.imm1_vld && opnd.imm2_vld))
        else $error("decd_operand_gen: both immediates valid, opcode 0x%0h", opcode);

endmodule

// File: source/decd_out_pkg.sv
package decd_out_pkg;

    // ======================================================================
    // Execution unit select
    // ======================================================================
    localparam int SEL_WIDTH = 5;

    typedef logic [SEL_WIDTH-1:0] sel_t;   // One-hot, or zero

    localparam sel_t SEL_NONE = 5'b00000;   // Unsupported encoding
    localparam sel_t SEL_ALU  = 5'b00001;
    localparam sel_t SEL_BJU  = 5'b00010;   // Branch and jump unit
    localparam sel_t SEL_LSU  = 5'b00100;
    localparam sel_t SEL_MUL  = 5'b01000;
    localparam sel_t SEL_DIV  = 5'b10000;

    // ======================================================================
    // Function codes
    // ======================================================================
    localparam int FUNC_WIDTH = 6;

    typedef logic [FUNC_WIDTH-1:0] func_t;

    localparam func_t FUNC_NONE   = 6'd0;

    // ALU
    localparam func_t FUNC_ADD    = 6'd1;
    localparam func_t FUNC_SUB    = 6'd2;
    localparam func_t FUNC_SLT    = 6'd3;
    localparam func_t FUNC_LTU    = 6'd4;
    localparam func_t FUNC_SLL    = 6'd5;
    localparam func_t FUNC_SRL    = 6'd6;
    localparam func_t FUNC_SRA    = 6'd7;
    localparam func_t FUNC_AND    = 6'd8;
    localparam func_t FUNC_OR     = 6'd9;
    localparam func_t FUNC_XOR    = 6'd10;

    // BJU
    localparam func_t FUNC_AUIPC  = 6'd11;
    localparam func_t FUNC_JAL    = 6'd12;
    localparam func_t FUNC_JALR   = 6'd13;
    localparam func_t FUNC_BEQ    = 6'd14;
    localparam func_t FUNC_BNE    = 6'd15;
    localparam func_t FUNC_BLT    = 6'd16;
    localparam func_t FUNC_BGE    = 6'd17;
    localparam func_t FUNC_BLTU   = 6'd18;
    localparam func_t FUNC_BGEU   = 6'd19;

    // LSU
    localparam func_t FUNC_LB     = 6'd20;
    localparam func_t FUNC_LH     = 6'd21;
    localparam func_t FUNC_LW     = 6'd22;
    localparam func_t FUNC_LBU    = 6'd23;
    localparam func_t FUNC_LHU    = 6'd24;
    localparam func_t FUNC_SB     = 6'd25;
    localparam func_t FUNC_SH     = 6'd26;
    localparam func_t FUNC_SW     = 6'd27;

    // MUL and DIV
    localparam func_t FUNC_MULT   = 6'd28;
    localparam func_t FUNC_MULH   = 6'd29;
    localparam func_t FUNC_MULHSU = 6'd30;
    localparam func_t FUNC_MULHU  = 6'd31;
    localparam func_t FUNC_DIVS   = 6'd32;
    localparam func_t FUNC_DIVU   = 6'd33;
    localparam func_t FUNC_REMS   = 6'd34;
    localparam func_t FUNC_REMU   = 6'd35;

    // ======================================================================
    // Decode results
    // ======================================================================
    typedef struct packed {
        sel_t  sel;
        func_t func;
        logic  rd_vld;      // Writes a destination register
    } decd_ctrl_t;

    typedef struct packed {
        logic                   rs1_vld;
        rv32_isa_pkg::reg_idx_t rs1;
        logic                   rs2_vld;
        logic                   imm1_vld;
        rv32_isa_pkg::imm_t     imm1;       // ALU immediate
        logic                   imm2_vld;
        rv32_isa_pkg::imm_t     imm2;       // BJU and LSU offset
    } decd_opnd_t;

    typedef struct packed {
        decd_ctrl_t ctrl;
        decd_opnd_t opnd;
    } decd_result_t;

endpackage

// File: source/decd_stage.sv
module decd_stage (
    input  logic                       cpuclk,
    input  logic                       arst_n,
    input  rv32_isa_pkg::inst_t        inst,
    input  logic                       inst_vld,
    output logic                       decd_vld,
    output decd_out_pkg::decd_result_t decd
);

    import decd_out_pkg::*;

    decd_ctrl_t   ctrl;
    decd_opnd_t   opnd;
    decd_result_t decd_nxt;

    // ======================================================================
    // Combinational decode
    // ======================================================================
    decd_func_decoder u_func_decoder
    (
        .inst (inst),
        .ctrl (ctrl)
    );

    decd_operand_gen u_operand_gen
    (
        .inst (inst),
        .opnd (opnd)
    );

    assign decd_nxt = '{ctrl: ctrl, opnd: opnd};

    // ======================================================================
    // Output register
    // ======================================================================
    always_ff @(posedge cpuclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            decd_vld <= 1'b0;
        end
        else
        begin
            decd_vld <= inst_vld;   // One cycle behind the strobe
        end
    end

    // Result only moves on a valid instruction, holds otherwise
    always_ff @(posedge cpuclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            decd <= '0;
        end
        else if (inst_vld)
        begin
            decd <= decd_nxt;
        end
    end

    // Downstream stages sample decd_vld every cycle
    a_vld_known: assert property (
        @(posedge cpuclk) disable iff (!arst_n)
        !$isunknown(decd_vld)
    ) else $error("decd_stage: decd_vld unknown after reset");

endmodule

// File: source/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // ======================================================================
    // Field widths
    // ======================================================================
    localparam int INST_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 5;
    localparam int OPC_WIDTH     = 5;   // Major opcode, bits 6 to 2
    localparam int FUNC3_WIDTH   = 3;
    localparam int FUNC7_WIDTH   = 7;

    typedef logic [INST_WIDTH-1:0]    inst_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [INST_WIDTH-1:0]    imm_t;     // Sign extended to full word
    typedef logic [OPC_WIDTH-1:0]     opcode_t;
    typedef logic [FUNC3_WIDTH-1:0]   func3_t;   // Bits 14 to 12
    typedef logic [FUNC7_WIDTH-1:0]   func7_t;   // Bits 31 to 25

    // ======================================================================
    // Major opcodes
    // ======================================================================
    // Loads and stores
    localparam opcode_t OPC_LOAD   = 5'b00000;
    localparam opcode_t OPC_STORE  = 5'b01000;

    // Arithmetic, immediate and register forms
    localparam opcode_t OPC_OP_IMM = 5'b00100;
    localparam opcode_t OPC_OP     = 5'b01100;   // Also carries RV32M

    // Upper immediates
    localparam opcode_t OPC_AUIPC  = 5'b00101;
    localparam opcode_t OPC_LUI    = 5'b01101;

    // Control transfer
    localparam opcode_t OPC_BRANCH = 5'b11000;
    localparam opcode_t OPC_JALR   = 5'b11001;
    localparam opcode_t OPC_JAL    = 5'b11011;

    // Bits 1 to 0 of every 32-bit encoding
    localparam logic [1:0] OPC_LOW_BITS = 2'b11;

endpackage
